// File: bench/ray_box_cases.txt
# name ox oy oz lo_x lo_y lo_z hi_x hi_y hi_z inv_x inv_y inv_z par_x par_y par_z hit
# origin, box bounds and reciprocals are signed integers, flags and hit are 0 or 1
pos_x 0 15 15 10 10 10 20 20 20 1 0 0 0 1 1 1
neg_x 30 15 15 10 10 10 20 20 20 -1 0 0 0 1 1 1
pos_y 15 0 15 10 10 10 20 20 20 0 2 0 1 0 1 1
neg_y 15 50 15 10 10 10 20 20 20 0 -3 0 1 0 1 1
pos_z 15 15 -5 10 10 10 20 20 20 0 0 4 1 1 0 1
neg_z 15 15 100 10 10 10 20 20 20 0 0 -1 1 1 0 1
diag_pos 0 0 0 10 10 10 20 20 20 1 1 1 0 0 0 1
diag_neg 30 30 30 10 10 10 20 20 20 -1 -1 -1 0 0 0 1
diag_mixed 0 30 0 10 10 10 20 20 20 1 -1 1 0 0 0 1
inside_pos 15 15 15 10 10 10 20 20 20 1 1 1 0 0 0 1
inside_neg 15 15 15 10 10 10 20 20 20 -2 3 -1 0 0 0 1
no_overlap_box 0 0 0 10 30 10 20 40 20 1 1 1 0 0 0 0
no_overlap_dir 0 0 0 10 10 10 20 20 20 1 4 1 0 0 0 0
skew_miss 0 0 0 10 10 10 20 20 20 1 1 3 0 0 0 0
corner_touch 0 0 0 10 10 10 20 20 20 2 1 1 0 0 0 1
behind_pos 30 15 15 10 10 10 20 20 20 1 0 0 0 1 1 0
behind_neg 0 15 15 10 10 10 20 20 20 -1 0 0 0 1 1 0
behind_all 30 30 30 10 10 10 20 20 20 1 1 1 0 0 0 0
exit_at_origin 20 15 15 10 10 10 20 20 20 1 0 0 0 1 1 0
exit_ahead 19 15 15 10 10 10 20 20 20 1 0 0 0 1 1 1
par_out_x 5 0 0 10 10 10 20 20 20 0 1 1 1 0 0 0
par_out_y 0 25 0 10 10 10 20 20 20 1 0 1 0 1 0 0
par_out_z 0 0 -1 10 10 10 20 20 20 1 1 0 0 0 1 0
par_out_two 30 30 0 10 10 10 20 20 20 0 0 1 1 1 0 0
par_in_x 15 0 0 10 10 10 20 20 20 0 1 1 1 0 0 1
par_in_lo_edge 10 0 0 10 10 10 20 20 20 0 1 1 1 0 0 1
par_in_hi_edge 0 20 0 10 10 10 20 20 20 1 0 1 0 1 0 1
par_in_gap 15 0 0 10 10 30 20 20 40 0 1 1 1 0 0 0
par_in_behind 15 30 30 10 10 10 20 20 20 0 1 1 1 0 0 0
par_all_in 15 15 15 10 10 10 20 20 20 0 0 0 1 1 1 1
par_all_out 15 15 25 10 10 10 20 20 20 0 0 0 1 1 1 0
neg_coord_miss -100 -50 -20 -40 -40 -40 -30 -30 -30 1 1 1 0 0 0 0
neg_coord_hit -100 -50 -20 -40 -40 0 -30 -30 10 1 6 3 0 0 0 1
large_pos -30000 0 0 30000 -10 -10 32767 10 10 1000 0 0 0 1 1 1
large_neg 32767 0 0 -32768 -10 -10 -32000 10 10 -32768 0 0 0 1 1 1
thin_slab 0 0 0 10 5 5 10 15 15 1 1 1 0 0 0 1

// File: bench/ray_box_tb.sv
`timescale 1ns/10ps
`include "ray_box_defines.svh"

module ray_box_tb;
	import ray_io_pkg::*;
	import slab_pkg::*;

	localparam int num_random  = 200;
	localparam int drain_limit = 4 * `RAY_BOX_LATENCY; // cycles allowed to empty the queue
	localparam int max_lines   = 1000;

	logic   clk;
	logic   rst;
	coord_t org[3]; // index 0..2 is x, y, z
	coord_t lo[3];
	coord_t hi[3];
	inv_t   inv[3];
	logic   par[3];
	logic   hit;

	// next ray, staged before it goes onto the pins
	coord_t n_org[3];
	coord_t n_lo[3];
	coord_t n_hi[3];
	inv_t   n_inv[3];
	logic   n_par[3];

	int     errors;
	int     checks;
	int     cycle; // falling edges since reset release
	string  name_q[$];
	logic   exp_q[$];
	int     due_q[$];

	ray_box_top dut_i (
		.clk      (clk),
		.rst      (rst),
		.origin_x (org[0]),
		.origin_y (org[1]),
		.origin_z (org[2]),
		.inv_x    (inv[0]),
		.inv_y    (inv[1]),
		.inv_z    (inv[2]),
		.par_x    (par[0]),
		.par_y    (par[1]),
		.par_z    (par[2]),
		.lo_x     (lo[0]),
		.lo_y     (lo[1]),
		.lo_z     (lo[2]),
		.hi_x     (hi[0]),
		.hi_y     (hi[1]),
		.hi_z     (hi[2]),
		.hit      (hit)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// reference model and checks
	//////////////////////////////////////////////////

	// slab method on the staged ray, exact integer math
	function automatic logic expected_hit();
		longint t_lo;
		longint t_hi;
		longint near;
		longint far;
		logic   miss;
		int     a;
		near = longint'(dist_neg_inf); // parallel axes leave these alone
		far  = longint'(dist_pos_inf);
		miss = 1'b0;
		for (a = 0; a < 3; a++) begin
			if (n_par[a]) begin
				if (n_org[a] < n_lo[a] || n_org[a] > n_hi[a]) begin
					miss = 1'b1; // origin outside a slab it never crosses
				end
			end else begin
				t_lo = (longint'(n_lo[a]) - longint'(n_org[a])) * longint'(n_inv[a]);
				t_hi = (longint'(n_hi[a]) - longint'(n_org[a])) * longint'(n_inv[a]);
				if (n_inv[a] < 0) begin
					if (t_hi > near) near = t_hi; // upper plane entered first
					if (t_lo < far) far = t_lo;
				end else begin
					if (t_lo > near) near = t_lo;
					if (t_hi < far) far = t_hi;
				end
			end
		end
		return !miss && (near <= far) && (far > 0);
	endfunction

	task automatic check_hit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic push_expected(input string name, input logic exp);
		name_q.push_back(name);
		exp_q.push_back(exp);
		due_q.push_back(cycle + `RAY_BOX_LATENCY);
	endtask

	task automatic check_due();
		string name;
		logic  exp;
		if (due_q.size() > 0 && due_q[0] == cycle) begin
			name = name_q.pop_front();
			exp  = exp_q.pop_front();
			void'(due_q.pop_front());
			check_hit(name, exp, hit);
		end else if (cycle < `RAY_BOX_LATENCY) begin
			check_hit("after_reset", 1'b0, hit); // pipeline still holds reset values
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic next_cycle();
		@(negedge clk);
		cycle++;
		check_due();
	endtask

	// staged ray goes onto the pins on this falling edge
	task automatic send_ray(input string name, input logic exp);
		int a;
		next_cycle();
		for (a = 0; a < 3; a++) begin
			org[a] = n_org[a];
			lo[a]  = n_lo[a];
			hi[a]  = n_hi[a];
			inv[a] = n_inv[a];
			par[a] = n_par[a];
		end
		push_expected(name, exp);
	endtask

	function automatic int rand_between(input int low, input int high);
		return low + int'($urandom % (high - low + 1));
	endfunction

	task automatic make_random_ray();
		int a;
		int low;
		for (a = 0; a < 3; a++) begin
			low      = rand_between(-100, 100);
			n_org[a] = coord_t'(rand_between(-200, 200));
			n_lo[a]  = coord_t'(low);
			n_hi[a]  = coord_t'(low + rand_between(0, 150)); // keeps lo <= hi
			n_inv[a] = inv_t'(rand_between(-300, 300));
			n_par[a] = (rand_between(0, 5) == 0);
		end
	endtask

	task automatic run_file_cases();
		int    fd;
		int    lines;
		int    got;
		string line;
		string name;
		int    ox, oy, oz;
		int    lx, ly, lz;
		int    hx, hy, hz;
		int    ix, iy, iz;
		int    px, py, pz;
		int    eh;
		fd = $fopen("bench/ray_box_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the cases file bench/ray_box_cases.txt");
			errors++;
			return;
		end
		lines = 0;
		while (!$feof(fd) && lines < max_lines) begin
			lines++;
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue; // blank or column notes
			end
			got = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				name, ox, oy, oz, lx, ly, lz, hx, hy, hz, ix, iy, iz, px, py, pz, eh);
			if (got != 17) begin
				$display("line %0d of the cases file has %0d fields instead of 17", lines, got);
				errors++;
				continue;
			end
			n_org[0] = coord_t'(ox);
			n_org[1] = coord_t'(oy);
			n_org[2] = coord_t'(oz);
			n_lo[0]  = coord_t'(lx);
			n_lo[1]  = coord_t'(ly);
			n_lo[2]  = coord_t'(lz);
			n_hi[0]  = coord_t'(hx);
			n_hi[1]  = coord_t'(hy);
			n_hi[2]  = coord_t'(hz);
			n_inv[0] = inv_t'(ix);
			n_inv[1] = inv_t'(iy);
			n_inv[2] = inv_t'(iz);
			n_par[0] = (px != 0);
			n_par[1] = (py != 0);
			n_par[2] = (pz != 0);
			send_ray(name, (eh != 0));
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int a;
		int n;
		int guard;
		void'($urandom(89));
		clk    = 1'b0;
		rst    = 1'b1;
		errors = 0;
		checks = 0;
		cycle  = 0;
		// a hitting ray sits on the pins through reset
		for (a = 0; a < 3; a++) begin
			org[a] = '0;
			lo[a]  = coord_t'(10);
			hi[a]  = coord_t'(20);
			inv[a] = inv_t'(1);
			par[a] = 1'b0;
		end
		repeat (2) begin
			@(negedge clk);
			check_hit("reset_hold", 1'b0, hit);
		end
		rst = 1'b0;
		push_expected("reset_ray", 1'b1);

		run_file_cases();

		for (n = 0; n < num_random; n++) begin
			make_random_ray();
			send_ray($sformatf("random_%0d", n), expected_hit());
		end

		guard = 0;
		while (due_q.size() > 0 && guard < drain_limit) begin
			next_cycle();
			guard++;
		end
		if (due_q.size() > 0) begin
			$display("timed out with %0d results never compared", due_q.size());
			errors++;
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: design/interval_merge.sv
`timescale 1ns/10ps

module interval_merge (
	input  logic            clk,
	input  logic            rst,
	input  slab_pkg::dist_t t_enter_x,
	input  slab_pkg::dist_t t_enter_y,
	input  slab_pkg::dist_t t_enter_z,
	input  slab_pkg::dist_t t_exit_x,
	input  slab_pkg::dist_t t_exit_y,
	input  slab_pkg::dist_t t_exit_z,
	input  logic            miss_x,
	input  logic            miss_y,
	input  logic            miss_z,
	output logic            hit
);
	import slab_pkg::*;

	dist_t near_d; // latest entry of the three
	dist_t far_d;  // earliest exit of the three
	dist_t t_near;
	dist_t t_far;
	logic  any_miss;

	//////////////////////////////////////////////////
	// stage 3: three way reduction
	//////////////////////////////////////////////////

	always_comb begin
		near_d = t_enter_x;
		if (t_enter_y > near_d) begin
			near_d = t_enter_y;
		end
		if (t_enter_z > near_d) begin
			near_d = t_enter_z;
		end

		far_d = t_exit_x;
		if (t_exit_y < far_d) begin
			far_d = t_exit_y;
		end
		if (t_exit_z < far_d) begin
			far_d = t_exit_z;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			t_near   <= '0;
			t_far    <= '0;
			any_miss <= 1'b0;
		end else begin
			t_near   <= near_d;
			t_far    <= far_d;
			any_miss <= miss_x | miss_y | miss_z; // parallel ray outside a slab
		end
	end

	//////////////////////////////////////////////////
	// stage 4: hit decision
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hit <= 1'b0;
		end else begin
			// intervals overlap and the exit lies ahead of the origin
			hit <= ~any_miss & (t_near <= t_far) & (t_far > dist_t'(0));
		end
	end

	// a parallel miss arrives together with its unbounded interval
	a_miss_unbounded: assert property (@(posedge clk) disable iff (rst)
		(!miss_x || (t_enter_x == dist_neg_inf && t_exit_x == dist_pos_inf)) &&
		(!miss_y || (t_enter_y == dist_neg_inf && t_exit_y == dist_pos_inf)) &&
		(!miss_z || (t_enter_z == dist_neg_inf && t_exit_z == dist_pos_inf)))
		else $error("interval_merge: parallel miss without an unbounded interval");

endmodule

// File: design/ray_box_defines.svh
`ifndef RAY_BOX_DEFINES_SVH
`define RAY_BOX_DEFINES_SVH

//////////////////////////////////////////////////
// ray and box input widths
//////////////////////////////////////////////////

// signed origin component or box bound
`define COORD_W 16

// signed reciprocal of one direction component
`define INV_W 16

//////////////////////////////////////////////////
// pipeline depth
//////////////////////////////////////////////////

// offset, scale, reduce, decide
`define RAY_BOX_LATENCY 4

`endif

// File: design/ray_box_top.sv
`timescale 1ns/10ps

module ray_box_top (
	input  logic               clk,
	input  logic               rst,
	input  ray_io_pkg::coord_t origin_x,
	input  ray_io_pkg::coord_t origin_y,
	input  ray_io_pkg::coord_t origin_z,
	input  ray_io_pkg::inv_t   inv_x,
	input  ray_io_pkg::inv_t   inv_y,
	input  ray_io_pkg::inv_t   inv_z,
	input  logic               par_x,
	input  logic               par_y,
	input  logic               par_z,
	input  ray_io_pkg::coord_t lo_x,
	input  ray_io_pkg::coord_t lo_y,
	input  ray_io_pkg::coord_t lo_z,
	input  ray_io_pkg::coord_t hi_x,
	input  ray_io_pkg::coord_t hi_y,
	input  ray_io_pkg::coord_t hi_z,
	output logic               hit
);
	import ray_io_pkg::*;
	import slab_pkg::*;

	//////////////////////////////////////////////////
	// stage 1 outputs
	//////////////////////////////////////////////////

	diff_t lo_diff_x;
	diff_t lo_diff_y;
	diff_t lo_diff_z;
	diff_t hi_diff_x;
	diff_t hi_diff_y;
	diff_t hi_diff_z;
	inv_t  inv_q_x;
	inv_t  inv_q_y;
	inv_t  inv_q_z;
	logic  par_q_x;
	logic  par_q_y;
	logic  par_q_z;
	logic  off_miss_x; // parallel miss after stage 1
	logic  off_miss_y;
	logic  off_miss_z;

	//////////////////////////////////////////////////
	// stage 2 outputs
	//////////////////////////////////////////////////

	dist_t t_enter_x;
	dist_t t_enter_y;
	dist_t t_enter_z;
	dist_t t_exit_x;
	dist_t t_exit_y;
	dist_t t_exit_z;
	logic  scl_miss_x; // same miss, one stage later
	logic  scl_miss_y;
	logic  scl_miss_z;

	// one offset and one scale stage per axis
	slab_offset offset_x_i (.clk(clk), .rst(rst), .origin(origin_x), .box_lo(lo_x),
		.box_hi(hi_x), .inv(inv_x), .parallel(par_x), .lo_diff(lo_diff_x),
		.hi_diff(hi_diff_x), .inv_q(inv_q_x), .parallel_q(par_q_x), .axis_miss(off_miss_x));
	slab_offset offset_y_i (.clk(clk), .rst(rst), .origin(origin_y), .box_lo(lo_y),
		.box_hi(hi_y), .inv(inv_y), .parallel(par_y), .lo_diff(lo_diff_y),
		.hi_diff(hi_diff_y), .inv_q(inv_q_y), .parallel_q(par_q_y), .axis_miss(off_miss_y));
	slab_offset offset_z_i (.clk(clk), .rst(rst), .origin(origin_z), .box_lo(lo_z),
		.box_hi(hi_z), .inv(inv_z), .parallel(par_z), .lo_diff(lo_diff_z),
		.hi_diff(hi_diff_z), .inv_q(inv_q_z), .parallel_q(par_q_z), .axis_miss(off_miss_z));

	slab_scale scale_x_i (.clk(clk), .rst(rst), .lo_diff(lo_diff_x), .hi_diff(hi_diff_x),
		.inv(inv_q_x), .parallel(par_q_x), .miss_in(off_miss_x), .t_enter(t_enter_x),
		.t_exit(t_exit_x), .axis_miss(scl_miss_x));
	slab_scale scale_y_i (.clk(clk), .rst(rst), .lo_diff(lo_diff_y), .hi_diff(hi_diff_y),
		.inv(inv_q_y), .parallel(par_q_y), .miss_in(off_miss_y), .t_enter(t_enter_y),
		.t_exit(t_exit_y), .axis_miss(scl_miss_y));
	slab_scale scale_z_i (.clk(clk), .rst(rst), .lo_diff(lo_diff_z), .hi_diff(hi_diff_z),
		.inv(inv_q_z), .parallel(par_q_z), .miss_in(off_miss_z), .t_enter(t_enter_z),
		.t_exit(t_exit_z), .axis_miss(scl_miss_z));

	// reduction and decision, two more stages
	interval_merge merge_i (
		.clk       (clk),
		.rst       (rst),
		.t_enter_x (t_enter_x),
		.t_enter_y (t_enter_y),
		.t_enter_z (t_enter_z),
		.t_exit_x  (t_exit_x),
		.t_exit_y  (t_exit_y),
		.t_exit_z  (t_exit_z),
		.miss_x    (scl_miss_x),
		.miss_y    (scl_miss_y),
		.miss_z    (scl_miss_z),
		.hit       (hit)
	);

endmodule

// File: design/ray_io_pkg.sv
`include "ray_box_defines.svh"

package ray_io_pkg;

	//////////////////////////////////////////////////
	// values arriving at the top level ports
	//////////////////////////////////////////////////

	// origin component or box plane position
	typedef logic signed [`COORD_W-1:0] coord_t;

	// 1/dir for one axis, same fixed point scale as the coordinates
	typedef logic signed [`INV_W-1:0] inv_t;

endpackage

// File: design/slab_offset.sv
`timescale 1ns/10ps
`include "ray_box_defines.svh"

module slab_offset (
	input  logic               clk,
	input  logic               rst,
	input  ray_io_pkg::coord_t origin,
	input  ray_io_pkg::coord_t box_lo,
	input  ray_io_pkg::coord_t box_hi,
	input  ray_io_pkg::inv_t   inv,
	input  logic               parallel,
	output slab_pkg::diff_t    lo_diff,
	output slab_pkg::diff_t    hi_diff,
	output ray_io_pkg::inv_t   inv_q,
	output logic               parallel_q,
	output logic               axis_miss
);
	import slab_pkg::*;

	diff_t lo_diff_d; // lower plane minus origin
	diff_t hi_diff_d; // upper plane minus origin
	logic  below_lo;
	logic  above_hi;
	logic  miss_d;

	//////////////////////////////////////////////////
	// widened offsets
	//////////////////////////////////////////////////

	assign lo_diff_d = {box_lo[`COORD_W-1], box_lo} - {origin[`COORD_W-1], origin};
	assign hi_diff_d = {box_hi[`COORD_W-1], box_hi} - {origin[`COORD_W-1], origin};

	// origin outside the closed slab, read off the offset signs
	assign below_lo = (lo_diff_d > diff_t'(0)); // origin < lower plane
	assign above_hi = hi_diff_d[diff_w-1]; // origin > upper plane

	assign miss_d = parallel & (below_lo | above_hi); // never crosses this slab

	//////////////////////////////////////////////////
	// stage 1 register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lo_diff    <= '0;
			hi_diff    <= '0;
			inv_q      <= '0;
			parallel_q <= 1'b0;
			axis_miss  <= 1'b0;
		end else begin
			lo_diff    <= lo_diff_d;
			hi_diff    <= hi_diff_d;
			inv_q      <= inv; // forwarded for the multiply
			parallel_q <= parallel;
			axis_miss  <= miss_d;
		end
	end

	// box must come in with ordered bounds
	a_bounds_ordered: assert property (@(posedge clk) disable iff (rst)
		box_lo <= box_hi)
		else $error("slab_offset: box_lo above box_hi");

endmodule

// File: design/slab_pkg.sv
`include "ray_box_defines.svh"

package slab_pkg;

	//////////////////////////////////////////////////
	// intermediate slab values
	//////////////////////////////////////////////////

	localparam int diff_w = `COORD_W + 1; // one guard bit for bound minus origin
	localparam int dist_w = diff_w + `INV_W; // full product, nothing dropped

	// box bound minus origin, cannot wrap
	typedef logic signed [diff_w-1:0] diff_t;

	// exact distance along the ray for one plane
	typedef logic signed [dist_w-1:0] dist_t;

	// limits of an unbounded interval, never reached by a real product
	localparam dist_t dist_neg_inf = {1'b1, {(dist_w - 1){1'b0}}};
	localparam dist_t dist_pos_inf = {1'b0, {(dist_w - 1){1'b1}}};

endpackage

// File: design/slab_scale.sv
`timescale 1ns/10ps
`include "ray_box_defines.svh"

module slab_scale (
	input  logic             clk,
	input  logic             rst,
	input  slab_pkg::diff_t  lo_diff,
	input  slab_pkg::diff_t  hi_diff,
	input  ray_io_pkg::inv_t inv,
	input  logic             parallel,
	input  logic             miss_in,
	output slab_pkg::dist_t  t_enter,
	output slab_pkg::dist_t  t_exit,
	output logic             axis_miss
);
	import slab_pkg::*;

	dist_t lo_prod; // distance to the lower plane
	dist_t hi_prod; // distance to the upper plane
	dist_t enter_d;
	dist_t exit_d;
	logic  inv_neg;

	//////////////////////////////////////////////////
	// exact products
	//////////////////////////////////////////////////

	// operands sign extended to full width first, result fits exactly
	assign lo_prod = dist_t'(lo_diff) * dist_t'(inv);
	assign hi_prod = dist_t'(hi_diff) * dist_t'(inv);

	assign inv_neg = inv[`INV_W-1]; // ray travels toward lower coordinates

	//////////////////////////////////////////////////
	// entry / exit ordering
	//////////////////////////////////////////////////

	always_comb begin
		if (parallel) begin
			// slab never crossed, axis leaves the other two to decide
			enter_d = dist_neg_inf;
			exit_d  = dist_pos_inf;
		end else if (inv_neg) begin
			enter_d = hi_prod; // upper plane reached first
			exit_d  = lo_prod;
		end else begin
			enter_d = lo_prod;
			exit_d  = hi_prod;
		end
	end

	//////////////////////////////////////////////////
	// stage 2 register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			t_enter   <= '0;
			t_exit    <= '0;
			axis_miss <= 1'b0;
		end else begin
			t_enter   <= enter_d;
			t_exit    <= exit_d;
			axis_miss <= miss_in; // carried along with the distances
		end
	end

	// ordered bounds upstream plus the swap give an ordered interval
	a_interval_ordered: assert property (@(posedge clk) disable iff (rst)
		t_enter <= t_exit)
		else $error("slab_scale: t_enter above t_exit");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ray/box testbench with Verilator, from the project root
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f sources.f --top-module ray_box_tb \
	--Mdir "$build_dir" -o ray_box_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/ray_box_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# verdict comes from the log only
if grep -qx "test passed" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1

// File: sources.f
+incdir+design
design/ray_io_pkg.sv
design/slab_pkg.sv
design/slab_offset.sv
design/slab_scale.sv
design/interval_merge.sv
design/ray_box_top.sv
bench/ray_box_tb.sv
